/* filelist.f */
+incdir+design
design/usbhid_pkg.sv
design/report_capture.sv
design/report_merge.sv
design/hex_char_stage.sv
design/apb_status_regs.sv
design/usbhid_monitor_top.sv
tests/usbhid_monitor_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := usbhid_monitor_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
PASS_MSG  := all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass message shows up in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tests/usbhid_monitor_tb.sv */
/*
 * testbench for usbhid_monitor_top, report and APB stimulus, reference model
 * and assertion checks on APB reads and the character pipeline
 */
`timescale 1ns/1ns
`default_nettype none

`include "usbhid_settings.svh"

module usbhid_monitor_tb;

  localparam int period      = 100;
  localparam int read_cycles = 3;
  // reset, ten register sweeps of 11 reads, merge polls, char requests
  localparam int stim_cycles = 10 + 10 * 11 * read_cycles + 40 * read_cycles + 60;
  localparam int watchdog_ns = (stim_cycles + 200) * period;

  logic                   clk_usb;
  logic                   reset;
  usbhid_pkg::report_in_t reports [`USBHID_PORTS];
  usbhid_pkg::char_req_t  char_req;
  usbhid_pkg::char_out_t  char_out;
  logic [7:0]             paddr;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [31:0]            pwdata;
  logic [31:0]            prdata;
  logic                   pready;
  logic                   pslverr;

  // reference model
  logic [63:0] exp_lane [`USBHID_PORTS];
  logic [15:0] exp_cnt [`USBHID_PORTS];
  logic [15:0] exp_total;
  logic [7:0]  exp_ovr [`USBHID_PORTS];
  logic [2:0]  exp_en;

  logic [31:0] exp_rdata;
  logic        exp_slverr;
  logic        check_rd;
  logic [31:0] rd_q;
  usbhid_pkg::char_out_t drv_exp;  // expected result of the request on char_req
  usbhid_pkg::char_out_t pipe1;
  usbhid_pkg::char_out_t pipe2;

  integer seed = 32'ha2f0_1125;
  int     errors = 0;
  int     reads = 0;
  int     chars = 0;

  usbhid_monitor_top u_dut (
    .clk_usb  (clk_usb),
    .reset    (reset),
    .reports  (reports),
    .char_req (char_req),
    .char_out (char_out),
    .paddr    (paddr),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr)
  );

  initial
  begin
    clk_usb = 1'b0;
    forever #(period / 2) clk_usb = ~clk_usb;
  end

  always @(posedge clk_usb)
  begin
    if (psel && penable)
      rd_q <= prdata;  // value seen in the access phase
    if (reset)
    begin
      pipe1 <= '0;
      pipe2 <= '0;
    end
    else
    begin
      pipe1 <= drv_exp;  // two cycle request to result delay
      pipe2 <= pipe1;
      if (char_out.valid)
        chars++;
    end
  end

  assert property (@(posedge clk_usb) disable iff (reset) pready == (psel && penable))
  else
  begin
    errors++;
    $display("[FAIL] pready got %h expected %h", pready, psel && penable);
  end

  assert property (@(posedge clk_usb) disable iff (reset)
    (psel && penable) |-> (pslverr == exp_slverr))
  else
  begin
    errors++;
    $display("[FAIL] pslverr addr %h got %h expected %h", paddr, pslverr, exp_slverr);
  end

  assert property (@(posedge clk_usb) disable iff (reset)
    (psel && penable && !pwrite && check_rd) |-> (prdata == exp_rdata))
  else
  begin
    errors++;
    $display("[FAIL] prdata addr %h got %h expected %h", paddr, $sampled(prdata),
             exp_rdata);
  end

  assert property (@(posedge clk_usb) disable iff (reset) char_out.valid == pipe2.valid)
  else
  begin
    errors++;
    $display("[FAIL] char_out.valid got %h expected %h", $sampled(char_out.valid),
             $sampled(pipe2.valid));
  end

  assert property (@(posedge clk_usb) disable iff (reset)
    pipe2.valid |-> (char_out.index == pipe2.index && char_out.ascii == pipe2.ascii))
  else
  begin
    errors++;
    $display("[FAIL] char_out index %h ascii got %h expected index %h ascii %h",
             $sampled(char_out.index), $sampled(char_out.ascii),
             $sampled(pipe2.index), $sampled(pipe2.ascii));
  end

  function automatic logic [7:0] hex_ascii(input logic [3:0] n);
    if (n < 4'd10)
      return "0" + {4'h0, n};
    else
      return "A" + {4'h0, n} - 8'd10;
  endfunction

  function automatic logic [`USBHID_DISP_BITS-1:0] model_buf();
    logic [`USBHID_DISP_BITS-1:0] b;
    b = '0;
    for (int p = 0; p < `USBHID_PORTS; p++)
    begin
      b[64*p +: 64]       = exp_lane[p];
      b[192 + 16*p +: 16] = exp_cnt[p];  // per-port counters above the lanes
    end
    b[240 +: 16] = exp_total;
    return b;
  endfunction

  task automatic apb_read(input logic [7:0] addr, input logic [31:0] exp_data,
                          input logic exp_err, input logic check, output logic [31:0] data);
    @(posedge clk_usb);
    #10;
    paddr      = addr;
    pwrite     = 1'b0;
    psel       = 1'b1;
    penable    = 1'b0;
    exp_rdata  = exp_data;
    exp_slverr = exp_err;
    check_rd   = check;
    @(posedge clk_usb);
    #10;
    penable = 1'b1;
    @(posedge clk_usb);
    #10;
    psel       = 1'b0;
    penable    = 1'b0;
    check_rd   = 1'b0;
    exp_slverr = 1'b0;
    data       = rd_q;
    reads++;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk_usb);
    #10;
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk_usb);
    #10;
    penable = 1'b1;
    @(posedge clk_usb);
    #10;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic check_regs();
    logic [`USBHID_DISP_BITS-1:0] b;
    logic [31:0] d;
    b = model_buf();
    for (int k = 0; k < 8; k++)
      apb_read(8'(4 * k), b[32*k +: 32], 1'b0, 1'b1, d);
    apb_read(8'h20, {8'h00, exp_ovr[2], exp_ovr[1], exp_ovr[0]}, 1'b0, 1'b1, d);
    apb_read(8'h24, 32'd0, 1'b0, 1'b1, d);
    apb_read(8'h28, {29'd0, exp_en}, 1'b0, 1'b1, d);
  endtask

  // poll the total counter until every staged report has been merged
  task automatic wait_merge();
    logic [31:0] d;
    int polls;
    polls = 0;
    apb_read(8'h1C, 32'd0, 1'b0, 1'b0, d);
    while (d[31:16] !== exp_total && polls < 20)
    begin
      apb_read(8'h1C, 32'd0, 1'b0, 1'b0, d);
      polls++;
    end
    if (d[31:16] !== exp_total)
    begin
      errors++;
      $display("merge did not finish, total counter stayed at %h", d[31:16]);
    end
  endtask

  task automatic report_cycle();
    @(posedge clk_usb);
    #10;
    for (int p = 0; p < `USBHID_PORTS; p++)
      reports[p].valid = 1'b0;
  endtask

  task automatic stage_report(input int p, input logic [63:0] data);
    reports[p].valid = 1'b1;
    reports[p].data  = data;
    if (exp_en[p])
    begin
      exp_lane[p] = data;
      exp_cnt[p]  = exp_cnt[p] + 16'd1;
      exp_total   = exp_total + 16'd1;
    end
  endtask

  task automatic char_request(input logic [5:0] idx, input logic valid);
    logic [`USBHID_DISP_BITS-1:0] b;
    b = model_buf();
    @(posedge clk_usb);
    #10;
    char_req.valid = valid;
    char_req.index = idx;
    drv_exp.valid  = valid;
    drv_exp.index  = idx;
    drv_exp.ascii  = hex_ascii(b[4*idx +: 4]);
  endtask

  task automatic clear_model();
    for (int p = 0; p < `USBHID_PORTS; p++)
    begin
      exp_lane[p] = '0;
      exp_cnt[p]  = '0;
      exp_ovr[p]  = '0;
    end
    exp_total = '0;
  endtask

  initial
  begin
    logic [31:0] d;
    reset    = 1'b1;
    char_req = '0;
    drv_exp  = '0;
    paddr    = '0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    pwdata   = '0;
    check_rd   = 1'b0;
    exp_rdata  = '0;
    exp_slverr = 1'b0;
    for (int p = 0; p < `USBHID_PORTS; p++)
      reports[p] = '0;
    clear_model();
    exp_en = 3'b111;
    repeat (10) @(posedge clk_usb);
    #10;
    reset = 1'b0;

    check_regs();
    apb_read(8'h40, 32'd0, 1'b1, 1'b0, d);  // unmapped

    for (int p = 0; p < `USBHID_PORTS; p++)
    begin
      report_cycle();
      stage_report(p, {$random(seed), $random(seed)});
      report_cycle();
      wait_merge();
      check_regs();
    end

    // all ports at once, then back to back on port 0
    report_cycle();
    for (int p = 0; p < `USBHID_PORTS; p++)
      stage_report(p, {$random(seed), $random(seed)});
    report_cycle();
    wait_merge();
    check_regs();
    stage_report(0, {$random(seed), $random(seed)});
    report_cycle();
    stage_report(0, {$random(seed), $random(seed)});
    exp_ovr[0] = exp_ovr[0] + 8'd1;  // second report lands on a pending slot
    report_cycle();
    wait_merge();
    check_regs();

    apb_write(8'h28, 32'h5);
    exp_en = 3'b101;
    report_cycle();
    stage_report(0, {$random(seed), $random(seed)});
    stage_report(1, {$random(seed), $random(seed)});
    report_cycle();
    wait_merge();
    check_regs();
    apb_write(8'h28, 32'h7);
    exp_en = 3'b111;

    for (int i = 0; i < 24; i++)
    begin
      char_request(6'($random(seed)), 1'b1);
      if (i % 5 == 4)
        char_request(6'd0, 1'b0);  // gap now and then
    end
    char_request(6'd0, 1'b0);
    repeat (4) @(posedge clk_usb);

    apb_write(8'h24, 32'h1);
    clear_model();
    check_regs();
    report_cycle();
    stage_report(2, {$random(seed), $random(seed)});
    report_cycle();
    wait_merge();
    check_regs();

    repeat (3) @(posedge clk_usb);
    $display("%0d register reads, %0d character results, %0d errors", reads, chars, errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  initial
  begin
    #(watchdog_ns);
    $display("watchdog expired before the tests finished, %0d errors so far", errors);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* design/usbhid_monitor_top.sv */
/*
 * usbhid_monitor_top, capture stages, merge, character pipeline and APB block
 */
`timescale 1ns/1ns
`default_nettype none

`include "usbhid_settings.svh"

module usbhid_monitor_top
(
  input  wire                          clk_usb,
  input  wire                          reset,
  input  wire usbhid_pkg::report_in_t  reports [`USBHID_PORTS],
  input  wire usbhid_pkg::char_req_t   char_req,
  output usbhid_pkg::char_out_t        char_out,
  input  wire [7:0]                    paddr,
  input  wire                          psel,
  input  wire                          penable,
  input  wire                          pwrite,
  input  wire [31:0]                   pwdata,
  output logic [31:0]                  prdata,
  output logic                         pready,
  output logic                         pslverr
);

  usbhid_pkg::slot_t              slots [`USBHID_PORTS];
  logic [`USBHID_PORTS-1:0]       grant;
  logic [`USBHID_PORTS-1:0]       port_en;
  logic [8*`USBHID_PORTS-1:0]     overruns;
  logic [`USBHID_DISP_BITS-1:0]   disp_buf;
  logic                           clear_pulse;

  for (genvar p = 0; p < `USBHID_PORTS; p++)
  begin : g_port
    report_capture #(
      .port_id (2'(p))
    ) u_capture (
      .clk_usb (clk_usb),
      .reset   (reset),
      .report  (reports[p]),
      .enable  (port_en[p]),
      .grant   (grant[p]),
      .clear   (clear_pulse),  // overrun counts clear with the buffer
      .slot    (slots[p]),
      .overrun (overruns[8*p +: 8])
    );
  end

  report_merge u_merge (
    .clk_usb  (clk_usb),
    .reset    (reset),
    .slots    (slots),
    .clear    (clear_pulse),
    .grant    (grant),
    .disp_buf (disp_buf)
  );

  hex_char_stage u_hex (
    .clk_usb  (clk_usb),
    .reset    (reset),
    .disp_buf (disp_buf),
    .req      (char_req),
    .char_out (char_out)
  );

  apb_status_regs u_apb (
    .clk_usb     (clk_usb),
    .reset       (reset),
    .paddr       (paddr),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .disp_buf    (disp_buf),
    .overruns    (overruns),
    .port_en     (port_en),
    .clear_pulse (clear_pulse)
  );

endmodule

`default_nettype wire

/* design/apb_status_regs.sv */
/*
 * apb_status_regs, zero wait APB slave for buffer readback,
 * overrun counts, port enables and buffer clear
 */
`timescale 1ns/1ns
`default_nettype none

`include "usbhid_settings.svh"

module apb_status_regs
(
  input  wire                            clk_usb,
  input  wire                            reset,
  input  wire [7:0]                      paddr,
  input  wire                            psel,
  input  wire                            penable,
  input  wire                            pwrite,
  input  wire [31:0]                     pwdata,
  output logic [31:0]                    prdata,
  output logic                           pready,
  output logic                           pslverr,
  input  wire [`USBHID_DISP_BITS-1:0]    disp_buf,
  input  wire [8*`USBHID_PORTS-1:0]      overruns,
  output logic [`USBHID_PORTS-1:0]       port_en,
  output logic                           clear_pulse
);

  usbhid_pkg::reg_addr_e addr;
  logic access;
  logic mapped;

  assign addr   = usbhid_pkg::reg_addr_e'(paddr);
  assign access = psel && penable;

  // read mux, decoded every cycle and sampled in the access phase
  always_comb
  begin
    mapped = 1'b1;
    prdata = 32'd0;
    case (addr)
      usbhid_pkg::REG_DISP0, usbhid_pkg::REG_DISP1,
      usbhid_pkg::REG_DISP2, usbhid_pkg::REG_DISP3,
      usbhid_pkg::REG_DISP4, usbhid_pkg::REG_DISP5,
      usbhid_pkg::REG_DISP6, usbhid_pkg::REG_DISP7:
        prdata = disp_buf[32*paddr[4:2] +: 32];
      usbhid_pkg::REG_OVERRUN:
        prdata = 32'(overruns);  // port 0 in the low byte
      usbhid_pkg::REG_CONTROL:
        prdata = 32'd0;
      usbhid_pkg::REG_PORT_EN:
        prdata = 32'(port_en);
      default:
        mapped = 1'b0;
    endcase
  end

  assign pready  = access;  // no wait states
  assign pslverr = access && !mapped;

  always_ff @(posedge clk_usb)
  begin
    if (reset)
    begin
      port_en     <= '1;
      clear_pulse <= 1'b0;
    end
    else
    begin
      clear_pulse <= 1'b0;
      if (access && pwrite)
      begin
        case (addr)
          usbhid_pkg::REG_CONTROL:
            clear_pulse <= pwdata[0];  // one cycle
          usbhid_pkg::REG_PORT_EN:
            port_en <= pwdata[`USBHID_PORTS-1:0];
          default:
            ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* design/hex_char_stage.sv */
/*
 * hex_char_stage, two cycle nibble to ASCII hex pipeline for the scanner
 */
`timescale 1ns/1ns
`default_nettype none

`include "usbhid_settings.svh"

module hex_char_stage
(
  input  wire                           clk_usb,
  input  wire                           reset,
  input  wire [`USBHID_DISP_BITS-1:0]   disp_buf,
  input  wire usbhid_pkg::char_req_t    req,
  output usbhid_pkg::char_out_t         char_out
);

  localparam int idx_bits = $clog2(`USBHID_CHARS);

  logic                valid_s1;
  logic [idx_bits-1:0] index_s1;
  logic [3:0]          nib_s1;
  logic                valid_s2;
  logic [idx_bits-1:0] index_s2;
  logic [7:0]          ascii_s2;

  always_ff @(posedge clk_usb)
  begin
    if (reset)
    begin
      valid_s1 <= 1'b0;
      valid_s2 <= 1'b0;
    end
    else
    begin
      valid_s1 <= req.valid;
      valid_s2 <= valid_s1;
    end
  end

  // stage one picks the nibble, stage two encodes it
  always_ff @(posedge clk_usb)
  begin
    index_s1 <= req.index;
    nib_s1   <= disp_buf[4*req.index +: 4];
    index_s2 <= index_s1;
    if (nib_s1 < 4'd10)
      ascii_s2 <= 8'h30 + {4'h0, nib_s1};  // '0'..'9'
    else
      ascii_s2 <= 8'h37 + {4'h0, nib_s1};  // 'A'..'F'
  end

  assign char_out.valid = valid_s2;
  assign char_out.index = index_s2;
  assign char_out.ascii = ascii_s2;

endmodule

`default_nettype wire

/* design/report_merge.sv */
/*
 * report_merge, fixed priority grant into the display buffer lanes
 * plus per-port and total report counters
 */
`timescale 1ns/1ns
`default_nettype none

`include "usbhid_settings.svh"

module report_merge
(
  input  wire                           clk_usb,
  input  wire                           reset,
  input  wire usbhid_pkg::slot_t        slots [`USBHID_PORTS],
  input  wire                           clear,
  output logic [`USBHID_PORTS-1:0]      grant,
  output logic [`USBHID_DISP_BITS-1:0]  disp_buf
);

  localparam int cnt_base = `USBHID_PORTS * `USBHID_SLOT_BITS;  // first counter bit
  localparam int total_lsb = `USBHID_DISP_BITS - 16;

  usbhid_pkg::merge_state_e state;
  logic       found;
  logic [1:0] sel;   // lowest pending port
  logic [1:0] lane;

  // lowest port number first
  always_comb
  begin
    found = 1'b0;
    sel   = 2'd0;
    for (int p = 0; p < `USBHID_PORTS; p++)
    begin
      if (slots[p].pending && !found)
      begin
        found = 1'b1;
        sel   = 2'(p);
      end
    end
  end

  always_comb
  begin
    if (clear)
      state = usbhid_pkg::ST_CLEAR;  // clear beats a grant, slot stays pending
    else if (found)
      state = usbhid_pkg::ST_WRITE;
    else
      state = usbhid_pkg::ST_IDLE;
  end

  assign grant = (state == usbhid_pkg::ST_WRITE) ? (`USBHID_PORTS'(1) << sel) : '0;
  assign lane  = slots[sel].port;

  always_ff @(posedge clk_usb)
  begin
    if (reset)
      disp_buf <= '0;
    else
    begin
      case (state)
        usbhid_pkg::ST_CLEAR:
          disp_buf <= '0;  // lanes and counters
        usbhid_pkg::ST_WRITE:
        begin
          disp_buf[`USBHID_SLOT_BITS*lane +: `USBHID_SLOT_BITS] <= slots[sel].data;
          disp_buf[cnt_base + 16*lane +: 16] <= disp_buf[cnt_base + 16*lane +: 16] + 16'd1;
          disp_buf[total_lsb +: 16] <= disp_buf[total_lsb +: 16] + 16'd1;  // wraps
        end
        default:
          ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/report_capture.sv */
/*
 * report_capture, one pending report slot per host port with overrun count
 */
`timescale 1ns/1ns
`default_nettype none

`include "usbhid_settings.svh"

module report_capture
#(
  parameter logic [1:0] port_id = 2'd0  // lane this stage feeds
)
(
  input  wire                    clk_usb,
  input  wire                    reset,
  input  wire usbhid_pkg::report_in_t report,
  input  wire                    enable,
  input  wire                    grant,
  input  wire                    clear,
  output usbhid_pkg::slot_t      slot,
  output logic [7:0]             overrun
);

  logic                         pending;
  logic [`USBHID_SLOT_BITS-1:0] data_q;  // payload of the pending report
  logic                         take;

  assign take = report.valid && enable;  // disabled ports drop reports

  always_ff @(posedge clk_usb)
  begin
    if (reset)
    begin
      pending <= 1'b0;
      overrun <= 8'd0;
    end
    else
    begin
      if (take)
        pending <= 1'b1;  // newest report always wins the slot
      else if (grant)
        pending <= 1'b0;

      if (clear)
        overrun <= 8'd0;
      else if (take && pending && overrun != 8'hFF)
        overrun <= overrun + 8'd1;  // new report onto a pending slot
    end
  end

  always_ff @(posedge clk_usb)
  begin
    if (take)
      data_q <= report.data;
  end

  assign slot.pending = pending;
  assign slot.port    = port_id;
  assign slot.data    = data_q;

endmodule

`default_nettype wire

/* design/usbhid_pkg.sv */
/*
 * shared structs and enums for capture, merge, character and APB stages
 */
`default_nettype none

`include "usbhid_settings.svh"

package usbhid_pkg;

  typedef struct packed {
    logic                          valid;
    logic [`USBHID_SLOT_BITS-1:0]  data;  // low 8 bytes of hid_report
  } report_in_t;

  typedef struct packed {
    logic                          pending;
    logic [1:0]                    port;
    logic [`USBHID_SLOT_BITS-1:0]  data;
  } slot_t;

  typedef struct packed {
    logic                              valid;
    logic [$clog2(`USBHID_CHARS)-1:0]  index;
  } char_req_t;

  typedef struct packed {
    logic                              valid;
    logic [$clog2(`USBHID_CHARS)-1:0]  index;
    logic [7:0]                        ascii;
  } char_out_t;

  // APB word addresses
  typedef enum logic [7:0] {
    REG_DISP0   = 8'h00,
    REG_DISP1   = 8'h04,
    REG_DISP2   = 8'h08,
    REG_DISP3   = 8'h0C,
    REG_DISP4   = 8'h10,
    REG_DISP5   = 8'h14,
    REG_DISP6   = 8'h18,
    REG_DISP7   = 8'h1C,
    REG_OVERRUN = 8'h20,
    REG_CONTROL = 8'h24,
    REG_PORT_EN = 8'h28
  } reg_addr_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE,
    ST_CLEAR
  } merge_state_e;

endpackage

`default_nettype wire

/* design/usbhid_settings.svh */
/*
 * port count, report slot width and display buffer sizes
 */
`ifndef USBHID_SETTINGS_SVH
`define USBHID_SETTINGS_SVH

// number of HID host ports feeding the monitor
`define USBHID_PORTS 3

// bits kept from each report, the low 8 bytes of hid_report
`define USBHID_SLOT_BITS 64

// display buffer, three slot lanes plus the counter word
`define USBHID_DISP_BITS 256

// hex digits across the whole buffer
`define USBHID_CHARS 64

`endif
